// File: logic/dm_cfg.svh
// debug module configuration: hart count, buffer sizes and field widths
`ifndef DM_CFG_SVH
`define DM_CFG_SVH

// harts behind this debug module
`define DM_NR_HARTS 4

// abstract data words and program buffer words
`define DM_DATA_COUNT 2
`define DM_PROGBUF_SIZE 8

// register word and DMI address widths
`define DM_WORD_W 32
`define DM_ADDR_W 7

// hartsel is hartselhi and hartsello together
`define DM_HARTSEL_W 20

// response queue entries toward the debugger
`define DM_RESP_DEPTH 2

`endif

// File: logic/dm_pkg.sv
// debug module types: register words, DMI addresses, hart vectors and encodings
`include "dm_cfg.svh"

package dm_pkg;

  typedef logic [`DM_WORD_W-1:0]    dm_word_t;
  typedef logic [`DM_ADDR_W-1:0]    dm_addr_t;
  typedef logic [`DM_NR_HARTS-1:0]  hart_vec_t;
  typedef logic [`DM_HARTSEL_W-1:0] hartsel_t;

  // DTM request operation
  typedef enum logic [1:0] {
    dtm_nop   = 2'd0,
    dtm_read  = 2'd1,
    dtm_write = 2'd2
  } dtm_op_e;

  // abstract command error, abstractcs.cmderr
  typedef enum logic [2:0] {
    cmderr_none          = 3'd0,
    cmderr_busy          = 3'd1,
    cmderr_not_supported = 3'd2,
    cmderr_exception     = 3'd3,
    cmderr_halt_resume   = 3'd4,
    cmderr_bus           = 3'd5,
    cmderr_other         = 3'd7
  } cmderr_e;

  // ----------------------------------------------------------------------
  // register map as seen over DMI
  // ----------------------------------------------------------------------
  typedef enum logic [`DM_ADDR_W-1:0] {
    csr_data0        = 7'h04,
    csr_data1        = 7'h05,
    csr_dmcontrol    = 7'h10,
    csr_dmstatus     = 7'h11,
    csr_abstractcs   = 7'h16,
    csr_command      = 7'h17,
    csr_abstractauto = 7'h18,
    csr_progbuf0     = 7'h20,
    csr_progbuf1     = 7'h21,
    csr_progbuf2     = 7'h22,
    csr_progbuf3     = 7'h23,
    csr_progbuf4     = 7'h24,
    csr_progbuf5     = 7'h25,
    csr_progbuf6     = 7'h26,
    csr_progbuf7     = 7'h27,
    csr_haltsum0     = 7'h40
  } dm_csr_e;

endpackage

// File: logic/dm_resp_fifo.sv
// response queue: small circular buffer of read words headed to the debugger
`timescale 1ns/1ns
`include "dm_cfg.svh"

module dm_resp_fifo (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  dm_pkg::dm_word_t data_i,
  input  logic             pop_i,
  output logic             full_o,
  output logic             empty_o,
  output dm_pkg::dm_word_t data_o
);

  localparam int unsigned PTR_W = (`DM_RESP_DEPTH > 1) ? $clog2(`DM_RESP_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(`DM_RESP_DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`DM_RESP_DEPTH - 1);

  dm_pkg::dm_word_t mem_q [`DM_RESP_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(`DM_RESP_DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // a pop frees its slot at the same edge, so push and pop may coincide
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: logic/dm_hart_ctrl.sv
// hart control bank: dmcontrol, havereset flags, dmstatus and haltsum0
`timescale 1ns/1ns
`include "dm_cfg.svh"

module dm_hart_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ctrl_wr_i,
  input  dm_pkg::dm_word_t   wdata_i,
  input  dm_pkg::hart_vec_t  halted_i,
  input  dm_pkg::hart_vec_t  unavailable_i,
  input  dm_pkg::hart_vec_t  resumeack_i,
  output dm_pkg::dm_word_t   dmcontrol_o,
  output dm_pkg::dm_word_t   dmstatus_o,
  output dm_pkg::dm_word_t   haltsum0_o,
  output dm_pkg::hart_vec_t  haltreq_o,
  output dm_pkg::hart_vec_t  resumereq_o,
  output logic               clear_resumeack_o,
  output logic               ndmreset_o,
  output logic               dmactive_o
);

  localparam int unsigned IDX_W = (`DM_NR_HARTS > 1) ? $clog2(`DM_NR_HARTS) : 1;

  logic              haltreq_q;
  logic              resumereq_q;
  logic              resumereq_d;
  logic              ndmreset_q;
  logic              dmactive_q;
  dm_pkg::hartsel_t  hartsel_q;
  dm_pkg::hart_vec_t havereset_q;
  dm_pkg::hart_vec_t havereset_d;

  logic [IDX_W-1:0]  sel_idx;
  logic              sel_exists;
  logic              sel_halted;
  logic              sel_unavail;
  logic              sel_resumeack;
  logic              sel_havereset;

  // ----------------------------------------------------------------------
  // selected hart
  // ----------------------------------------------------------------------
  assign sel_idx       = hartsel_q[IDX_W-1:0];
  assign sel_exists    = (hartsel_q < dm_pkg::hartsel_t'(`DM_NR_HARTS));
  assign sel_halted    = sel_exists & halted_i[sel_idx];
  assign sel_unavail   = sel_exists & unavailable_i[sel_idx];
  assign sel_resumeack = sel_exists & resumeack_i[sel_idx];
  assign sel_havereset = sel_exists & havereset_q[sel_idx];

  // dmcontrol only keeps haltreq, resumereq, hartsel, ndmreset and dmactive
  assign dmcontrol_o = {haltreq_q, resumereq_q, 4'b0000, hartsel_q[9:0],
                        hartsel_q[19:10], 4'b0000, ndmreset_q, dmactive_q};

  always_comb begin
    dmstatus_o        = '0;
    dmstatus_o[3:0]   = 4'd2;
    dmstatus_o[7]     = 1'b1;
    // halted and running never show for an unavailable hart
    dmstatus_o[9:8]   = {2{sel_halted & ~sel_unavail}};
    dmstatus_o[11:10] = {2{sel_exists & ~sel_halted & ~sel_unavail}};
    dmstatus_o[13:12] = {2{sel_unavail}};
    dmstatus_o[15:14] = {2{~sel_exists}};
    dmstatus_o[17:16] = {2{sel_resumeack}};
    dmstatus_o[19:18] = {2{sel_havereset}};
  end

  assign haltsum0_o = {{(`DM_WORD_W - `DM_NR_HARTS){1'b0}}, halted_i};

  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (sel_exists) begin
      haltreq_o[sel_idx]   = haltreq_q;
      resumereq_o[sel_idx] = resumereq_q;
    end
  end

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------
  always_comb begin
    resumereq_d = resumereq_q;
    if (ctrl_wr_i) begin
      resumereq_d = wdata_i[0] & wdata_i[30];
    end
    // the hart acknowledged, drop the request
    if (resumereq_q && sel_resumeack) begin
      resumereq_d = 1'b0;
    end
  end

  assign clear_resumeack_o = ~resumereq_q & resumereq_d;

  always_comb begin
    havereset_d = havereset_q;
    if (ctrl_wr_i && wdata_i[28] && sel_exists) begin
      havereset_d[sel_idx] = 1'b0;
    end
    if (ndmreset_q) begin
      havereset_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      haltreq_q   <= 1'b0;
      resumereq_q <= 1'b0;
      ndmreset_q  <= 1'b0;
      dmactive_q  <= 1'b0;
      hartsel_q   <= '0;
      havereset_q <= '1;
    end else begin
      // a write without dmactive leaves every other field clear
      if (ctrl_wr_i) begin
        dmactive_q <= wdata_i[0];
        haltreq_q  <= wdata_i[0] & wdata_i[31];
        ndmreset_q <= wdata_i[0] & wdata_i[1];
        hartsel_q  <= wdata_i[0] ? {wdata_i[15:6], wdata_i[25:16]} : '0;
      end
      resumereq_q <= resumereq_d;
      havereset_q <= havereset_d;
    end
  end

  assign ndmreset_o = ndmreset_q;
  assign dmactive_o = dmactive_q;

endmodule

// File: logic/dm_abstract_regs.sv
// abstract command bank: abstractcs, command, abstractauto, data and progbuf
`timescale 1ns/1ns
`include "dm_cfg.svh"

module dm_abstract_regs (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    dmactive_i,
  input  logic                                    req_i,
  input  dm_pkg::dtm_op_e                         op_i,
  input  dm_pkg::dm_addr_t                        addr_i,
  input  dm_pkg::dm_word_t                        wdata_i,
  input  logic                                    cmdbusy_i,
  input  logic                                    cmderror_valid_i,
  input  dm_pkg::cmderr_e                         cmderror_i,
  input  logic                                    data_valid_i,
  input  dm_pkg::dm_word_t [`DM_DATA_COUNT-1:0]   data_i,
  output dm_pkg::dm_word_t                        rdata_o,
  output logic                                    cmd_valid_o,
  output dm_pkg::dm_word_t                        cmd_o,
  output dm_pkg::dm_word_t [`DM_DATA_COUNT-1:0]   data_o,
  output dm_pkg::dm_word_t [`DM_PROGBUF_SIZE-1:0] progbuf_o
);

  localparam int unsigned DIDX_W = (`DM_DATA_COUNT > 1) ? $clog2(`DM_DATA_COUNT) : 1;
  localparam int unsigned PIDX_W = (`DM_PROGBUF_SIZE > 1) ? $clog2(`DM_PROGBUF_SIZE) : 1;
  localparam dm_pkg::dm_addr_t DATA_BASE = dm_pkg::csr_data0;
  localparam dm_pkg::dm_addr_t PB_BASE   = dm_pkg::csr_progbuf0;

  dm_pkg::cmderr_e                        cmderr_q, cmderr_d;
  logic                                   cmd_valid_q, cmd_valid_d;
  logic [`DM_DATA_COUNT-1:0]              auto_data_q, auto_data_d;
  logic [`DM_PROGBUF_SIZE-1:0]            auto_pb_q, auto_pb_d;
  dm_pkg::dm_word_t                       command_q, command_d;
  dm_pkg::dm_word_t [`DM_DATA_COUNT-1:0]   data_q, data_d;
  dm_pkg::dm_word_t [`DM_PROGBUF_SIZE-1:0] progbuf_q, progbuf_d;

  logic              wr;
  logic              acc;
  logic              data_hit;
  logic              pb_hit;
  logic [DIDX_W-1:0] data_idx;
  logic [PIDX_W-1:0] pb_idx;
  logic              busy_err;

  assign wr  = req_i & (op_i == dm_pkg::dtm_write);
  assign acc = req_i & ((op_i == dm_pkg::dtm_write) | (op_i == dm_pkg::dtm_read));

  assign data_hit = (addr_i >= DATA_BASE) &&
                    (addr_i < DATA_BASE + dm_pkg::dm_addr_t'(`DM_DATA_COUNT));
  assign pb_hit   = (addr_i >= PB_BASE) &&
                    (addr_i < PB_BASE + dm_pkg::dm_addr_t'(`DM_PROGBUF_SIZE));
  assign data_idx = DIDX_W'(addr_i - DATA_BASE);
  assign pb_idx   = PIDX_W'(addr_i - PB_BASE);

  // ----------------------------------------------------------------------
  // read mux and write decode
  // ----------------------------------------------------------------------
  always_comb begin
    rdata_o     = '0;
    busy_err    = 1'b0;
    cmderr_d    = cmderr_q;
    cmd_valid_d = 1'b0;
    auto_data_d = auto_data_q;
    auto_pb_d   = auto_pb_q;
    command_d   = command_q;
    data_d      = data_q;
    progbuf_d   = progbuf_q;

    if (data_hit) begin
      rdata_o = data_q[data_idx];
      if (wr && cmdbusy_i) begin
        busy_err = 1'b1;
      end else if (wr) begin
        data_d[data_idx] = wdata_i;
      end
      // autoexec on any access while idle
      if (acc && !cmdbusy_i) begin
        cmd_valid_d = auto_data_q[data_idx];
      end
    end else if (pb_hit) begin
      rdata_o = progbuf_q[pb_idx];
      if (wr && cmdbusy_i) begin
        busy_err = 1'b1;
      end else if (wr) begin
        progbuf_d[pb_idx] = wdata_i;
      end
      if (acc && !cmdbusy_i) begin
        cmd_valid_d = auto_pb_q[pb_idx];
      end
    end else begin
      case (addr_i)
        dm_pkg::csr_abstractcs: begin
          rdata_o[28:24] = 5'(`DM_PROGBUF_SIZE);
          rdata_o[12]    = cmdbusy_i;
          rdata_o[10:8]  = cmderr_q;
          rdata_o[3:0]   = 4'(`DM_DATA_COUNT);
          if (wr && cmdbusy_i) begin
            busy_err = 1'b1;
          end else if (wr) begin
            // cmderr is write-one-to-clear
            cmderr_d = dm_pkg::cmderr_e'(cmderr_q & ~wdata_i[10:8]);
          end
        end
        dm_pkg::csr_command: begin
          if (wr && cmdbusy_i) begin
            busy_err = 1'b1;
          end else if (wr) begin
            command_d   = wdata_i;
            cmd_valid_d = 1'b1;
          end
        end
        dm_pkg::csr_abstractauto: begin
          rdata_o[`DM_DATA_COUNT-1:0]     = auto_data_q;
          rdata_o[16 +: `DM_PROGBUF_SIZE] = auto_pb_q;
          if (wr && cmdbusy_i) begin
            busy_err = 1'b1;
          end else if (wr) begin
            auto_data_d = wdata_i[`DM_DATA_COUNT-1:0];
            auto_pb_d   = wdata_i[16 +: `DM_PROGBUF_SIZE];
          end
        end
        default: ;
      endcase
    end

    if (busy_err && cmderr_q == dm_pkg::cmderr_none) begin
      cmderr_d = dm_pkg::cmderr_busy;
    end
    // the hart's own error report wins over the debugger
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  // ----------------------------------------------------------------------
  // registers, all cleared while the module is inactive
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= dm_pkg::cmderr_none;
      cmd_valid_q <= 1'b0;
      auto_data_q <= '0;
      auto_pb_q   <= '0;
    end else if (!dmactive_i) begin
      cmderr_q    <= dm_pkg::cmderr_none;
      cmd_valid_q <= 1'b0;
      auto_data_q <= '0;
      auto_pb_q   <= '0;
    end else begin
      cmderr_q    <= cmderr_d;
      cmd_valid_q <= cmd_valid_d;
      auto_data_q <= auto_data_d;
      auto_pb_q   <= auto_pb_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!dmactive_i) begin
      command_q <= '0;
      data_q    <= '0;
      progbuf_q <= '0;
    end else begin
      command_q <= command_d;
      data_q    <= data_d;
      progbuf_q <= progbuf_d;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;
  assign progbuf_o   = progbuf_q;

endmodule

// File: logic/dm_csrs.sv
// debug module register block: DMI request decode, register banks, response queue
`timescale 1ns/1ns
`include "dm_cfg.svh"

module dm_csrs (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    dmi_req_valid_i,
  input  dm_pkg::dm_addr_t                        dmi_req_addr_i,
  input  dm_pkg::dtm_op_e                         dmi_req_op_i,
  input  dm_pkg::dm_word_t                        dmi_req_data_i,
  output logic                                    dmi_req_ready_o,
  output logic                                    dmi_resp_valid_o,
  input  logic                                    dmi_resp_ready_i,
  output dm_pkg::dm_word_t                        dmi_resp_data_o,
  input  dm_pkg::hart_vec_t                       halted_i,
  input  dm_pkg::hart_vec_t                       unavailable_i,
  input  dm_pkg::hart_vec_t                       resumeack_i,
  output dm_pkg::hartsel_t                        hartsel_o,
  output dm_pkg::hart_vec_t                       haltreq_o,
  output dm_pkg::hart_vec_t                       resumereq_o,
  output logic                                    clear_resumeack_o,
  output logic                                    ndmreset_o,
  output logic                                    dmactive_o,
  output logic                                    cmd_valid_o,
  output dm_pkg::dm_word_t                        cmd_o,
  input  logic                                    cmdbusy_i,
  input  logic                                    cmderror_valid_i,
  input  dm_pkg::cmderr_e                         cmderror_i,
  input  logic                                    data_valid_i,
  input  dm_pkg::dm_word_t [`DM_DATA_COUNT-1:0]   data_i,
  output dm_pkg::dm_word_t [`DM_DATA_COUNT-1:0]   data_o,
  output dm_pkg::dm_word_t [`DM_PROGBUF_SIZE-1:0] progbuf_o
);

  localparam dm_pkg::dm_addr_t DATA_FIRST = dm_pkg::csr_data0;
  localparam dm_pkg::dm_addr_t DATA_LAST  =
    dm_pkg::dm_addr_t'(dm_pkg::csr_data0 + `DM_DATA_COUNT - 1);
  localparam dm_pkg::dm_addr_t PB_FIRST   = dm_pkg::csr_progbuf0;
  localparam dm_pkg::dm_addr_t PB_LAST    =
    dm_pkg::dm_addr_t'(dm_pkg::csr_progbuf0 + `DM_PROGBUF_SIZE - 1);

  logic             req_accept;
  logic             req_read;
  logic             ctrl_wr;
  logic             abs_req;
  logic             fifo_full;
  logic             fifo_empty;
  dm_pkg::dm_word_t resp_word;
  dm_pkg::dm_word_t dmcontrol;
  dm_pkg::dm_word_t dmstatus;
  dm_pkg::dm_word_t haltsum0;
  dm_pkg::dm_word_t abs_rdata;

  assign dmi_req_ready_o  = ~fifo_full;
  assign dmi_resp_valid_o = ~fifo_empty;
  assign req_accept       = dmi_req_valid_i & dmi_req_ready_o;
  assign req_read         = (dmi_req_op_i == dm_pkg::dtm_read);

  // ----------------------------------------------------------------------
  // region decode, one strobe per bank
  // ----------------------------------------------------------------------
  always_comb begin
    resp_word = '0;
    ctrl_wr   = 1'b0;
    abs_req   = 1'b0;
    case (dmi_req_addr_i) inside
      dm_pkg::csr_dmcontrol: begin
        resp_word = dmcontrol;
        ctrl_wr   = req_accept & (dmi_req_op_i == dm_pkg::dtm_write);
      end
      dm_pkg::csr_dmstatus: resp_word = dmstatus;
      dm_pkg::csr_haltsum0: resp_word = haltsum0;
      [DATA_FIRST:DATA_LAST], [PB_FIRST:PB_LAST], dm_pkg::csr_abstractcs,
      dm_pkg::csr_command, dm_pkg::csr_abstractauto: begin
        resp_word = abs_rdata;
        abs_req   = req_accept;
      end
      default: ;
    endcase
    // writes and nops answer with zero
    if (!req_read) begin
      resp_word = '0;
    end
  end

  assign hartsel_o = {dmcontrol[15:6], dmcontrol[25:16]};

  dm_hart_ctrl i_hart_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ctrl_wr_i         (ctrl_wr),
    .wdata_i           (dmi_req_data_i),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .dmcontrol_o       (dmcontrol),
    .dmstatus_o        (dmstatus),
    .haltsum0_o        (haltsum0),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o)
  );

  dm_abstract_regs i_abstract_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmactive_i       (dmactive_o),
    .req_i            (abs_req),
    .op_i             (dmi_req_op_i),
    .addr_i           (dmi_req_addr_i),
    .wdata_i          (dmi_req_data_i),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .rdata_o          (abs_rdata),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o),
    .progbuf_o        (progbuf_o)
  );

  // every accepted request leaves exactly one response word
  dm_resp_fifo i_resp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_accept),
    .data_i  (resp_word),
    .pop_i   (dmi_resp_ready_i),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .data_o  (dmi_resp_data_o)
  );

endmodule

// File: testbench/tb_dm_csrs.sv
// testbench for the debug module register block: DMI driver, shadow model and checks
`timescale 1ns/1ns
`include "dm_cfg.svh"

module tb_dm_csrs;

  logic clk_i;
  logic rst_ni;
  logic req_valid;
  dm_pkg::dm_addr_t req_addr;
  dm_pkg::dtm_op_e req_op;
  dm_pkg::dm_word_t req_data;
  logic resp_ready;
  dm_pkg::hart_vec_t halted;
  dm_pkg::hart_vec_t unavail;
  dm_pkg::hart_vec_t resumeack;
  logic cmdbusy;
  logic cmderr_valid;
  dm_pkg::cmderr_e cmderr_in;
  logic data_valid;
  dm_pkg::dm_word_t [`DM_DATA_COUNT-1:0] data_in;

  logic req_ready;
  logic resp_valid;
  dm_pkg::dm_word_t resp_data;
  dm_pkg::hartsel_t hartsel;
  dm_pkg::hart_vec_t haltreq;
  dm_pkg::hart_vec_t resumereq;
  logic clear_resumeack;
  logic ndmreset;
  logic dmactive;
  logic cmd_valid;
  dm_pkg::dm_word_t cmd;
  dm_pkg::dm_word_t [`DM_DATA_COUNT-1:0] data_out;
  dm_pkg::dm_word_t [`DM_PROGBUF_SIZE-1:0] progbuf_out;

  // shadow model of the registers
  logic sh_act;
  logic sh_ndm;
  logic sh_halt;
  logic sh_resume;
  dm_pkg::hartsel_t sh_sel;
  dm_pkg::hart_vec_t sh_hr;
  dm_pkg::dm_word_t sh_data [`DM_DATA_COUNT];
  dm_pkg::dm_word_t sh_pb [`DM_PROGBUF_SIZE];
  logic [`DM_DATA_COUNT-1:0] sh_auto_d;
  logic [`DM_PROGBUF_SIZE-1:0] sh_auto_p;
  logic [2:0] sh_cmderr;

  dm_pkg::dm_word_t resp_q[$];
  int errors;
  int checks;
  int cmd_pulses;
  int cra_pulses;
  dm_pkg::dm_word_t last_cmd;
  int seed;

  dm_csrs uut (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .dmi_req_valid_i(req_valid), .dmi_req_addr_i(req_addr),
    .dmi_req_op_i(req_op), .dmi_req_data_i(req_data),
    .dmi_req_ready_o(req_ready), .dmi_resp_valid_o(resp_valid),
    .dmi_resp_ready_i(resp_ready), .dmi_resp_data_o(resp_data),
    .halted_i(halted), .unavailable_i(unavail), .resumeack_i(resumeack),
    .hartsel_o(hartsel), .haltreq_o(haltreq), .resumereq_o(resumereq),
    .clear_resumeack_o(clear_resumeack), .ndmreset_o(ndmreset), .dmactive_o(dmactive),
    .cmd_valid_o(cmd_valid), .cmd_o(cmd), .cmdbusy_i(cmdbusy),
    .cmderror_valid_i(cmderr_valid), .cmderror_i(cmderr_in),
    .data_valid_i(data_valid), .data_i(data_in),
    .data_o(data_out), .progbuf_o(progbuf_out)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------
  // monitors: response queue, command and resumeack pulses
  // ------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_ni && resp_valid && resp_ready) begin
      resp_q.push_back(resp_data);
    end
    if (cmd_valid) begin
      cmd_pulses++;
      last_cmd = cmd;
    end
    if (clear_resumeack) begin
      cra_pulses++;
    end
  end

  function automatic dm_pkg::dm_word_t ref_read(input dm_pkg::dm_addr_t addr);
    dm_pkg::dm_word_t w;
    int i;
    logic h;
    logic u;
    w = '0;
    i = int'(sh_sel[1:0]);
    case (addr) inside
      7'h10: begin
        w[31] = sh_halt;
        w[30] = sh_resume;
        w[25:16] = sh_sel[9:0];
        w[15:6] = sh_sel[19:10];
        w[1] = sh_ndm;
        w[0] = sh_act;
      end
      7'h11: begin
        w[3:0] = 4'd2;
        w[7] = 1'b1;
        if (sh_sel < `DM_NR_HARTS) begin
          h = halted[i];
          u = unavail[i];
          w[9:8] = {2{h & ~u}};
          w[11:10] = {2{~h & ~u}};
          w[13:12] = {2{u}};
          w[17:16] = {2{resumeack[i]}};
          w[19:18] = {2{sh_hr[i]}};
        end else begin
          w[15:14] = 2'b11;
        end
      end
      7'h40: w[`DM_NR_HARTS-1:0] = halted;
      7'h16: begin
        w[28:24] = `DM_PROGBUF_SIZE;
        w[12] = cmdbusy;
        w[10:8] = sh_cmderr;
        w[3:0] = `DM_DATA_COUNT;
      end
      7'h18: begin
        w[`DM_DATA_COUNT-1:0] = sh_auto_d;
        w[16 +: `DM_PROGBUF_SIZE] = sh_auto_p;
      end
      [7'h04:7'h05]: w = sh_data[addr - 7'h04];
      [7'h20:7'h27]: w = sh_pb[addr - 7'h20];
      default: w = '0;
    endcase
    return w;
  endfunction

  task automatic clear_abstract_shadow();
    for (int k = 0; k < `DM_DATA_COUNT; k++) sh_data[k] = '0;
    for (int k = 0; k < `DM_PROGBUF_SIZE; k++) sh_pb[k] = '0;
    sh_auto_d = '0;
    sh_auto_p = '0;
    sh_cmderr = 3'd0;
  endtask

  task automatic model_write(input dm_pkg::dm_addr_t addr, input dm_pkg::dm_word_t d);
    logic abs_hit;
    abs_hit = (addr inside {[7'h04:7'h05], [7'h16:7'h18], [7'h20:7'h27]});
    if (addr == 7'h10) begin
      if (d[28] && sh_sel < `DM_NR_HARTS) sh_hr[sh_sel[1:0]] = 1'b0;
      if (sh_ndm) sh_hr = '1;
      sh_act = d[0];
      sh_halt = d[0] & d[31];
      sh_resume = d[0] & d[30];
      sh_ndm = d[0] & d[1];
      sh_sel = d[0] ? {d[15:6], d[25:16]} : '0;
      if (sh_ndm) sh_hr = '1;
      if (!sh_act) clear_abstract_shadow();
    end else if (abs_hit && cmdbusy) begin
      if (sh_cmderr == 3'd0) sh_cmderr = 3'd1;
    end else if (addr == 7'h16) begin
      sh_cmderr = sh_cmderr & ~d[10:8];
    end else if (addr == 7'h18) begin
      sh_auto_d = d[`DM_DATA_COUNT-1:0];
      sh_auto_p = d[16 +: `DM_PROGBUF_SIZE];
    end else if (addr inside {[7'h04:7'h05]}) begin
      sh_data[addr - 7'h04] = d;
    end else if (addr inside {[7'h20:7'h27]}) begin
      sh_pb[addr - 7'h20] = d;
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout while waiting for %s", what);
    $display("sim failed");
    $finish;
  endtask

  task automatic check_eq(input dm_pkg::dm_word_t got, input dm_pkg::dm_word_t exp,
                          input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic send(input dm_pkg::dtm_op_e op, input dm_pkg::dm_addr_t addr,
                      input dm_pkg::dm_word_t d);
    int n;
    n = 0;
    req_valid = 1'b1;
    req_op = op;
    req_addr = addr;
    req_data = d;
    while (!req_ready) begin
      @(posedge clk_i);
      #2;
      n++;
      if (n > 50) timed_out("request ready");
    end
    @(posedge clk_i);
    #2;
    req_valid = 1'b0;
    req_op = dm_pkg::dtm_nop;
  endtask

  task automatic get_resp(output dm_pkg::dm_word_t w);
    int n;
    n = 0;
    while (resp_q.size() == 0) begin
      @(posedge clk_i);
      #2;
      n++;
      if (n > 50) timed_out("a DMI response");
    end
    w = resp_q.pop_front();
  endtask

  task automatic dmi_write(input dm_pkg::dm_addr_t addr, input dm_pkg::dm_word_t d);
    dm_pkg::dm_word_t w;
    send(dm_pkg::dtm_write, addr, d);
    model_write(addr, d);
    get_resp(w);
    check_eq(w, '0, "write response");
  endtask

  task automatic dmi_read(input dm_pkg::dm_addr_t addr, output dm_pkg::dm_word_t w);
    send(dm_pkg::dtm_read, addr, '0);
    get_resp(w);
  endtask

  task automatic check_read(input dm_pkg::dm_addr_t addr, input string msg);
    dm_pkg::dm_word_t w;
    dmi_read(addr, w);
    check_eq(w, ref_read(addr), msg);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  initial begin
    dm_pkg::dm_word_t w;
    dm_pkg::dm_word_t exp0;
    dm_pkg::dm_word_t exp1;
    seed = 32'h8c8b_62de;
    errors = 0;
    checks = 0;
    cmd_pulses = 0;
    cra_pulses = 0;
    rst_ni = 1'b0;
    req_valid = 1'b0;
    req_addr = '0;
    req_op = dm_pkg::dtm_nop;
    req_data = '0;
    resp_ready = 1'b1;
    halted = '0;
    unavail = '0;
    resumeack = '0;
    cmdbusy = 1'b0;
    cmderr_valid = 1'b0;
    cmderr_in = dm_pkg::cmderr_none;
    data_valid = 1'b0;
    data_in = '0;
    sh_act = 1'b0;
    sh_ndm = 1'b0;
    sh_halt = 1'b0;
    sh_resume = 1'b0;
    sh_sel = '0;
    sh_hr = '1;
    clear_abstract_shadow();
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // ------------------------------------------------------------------
    // dmactive gating and hart control
    // ------------------------------------------------------------------
    check_read(7'h10, "dmcontrol after reset");
    check_read(7'h11, "havereset after reset");
    dmi_write(7'h10, 32'h8000_0000);
    check_read(7'h10, "dmcontrol write without dmactive");
    // hartsello 2 and hartselhi 1
    dmi_write(7'h10, 32'h0002_0041);
    check_eq(dmactive, 1'b1, "dmactive_o set");
    check_eq(hartsel, 32'h0000_0402, "hartsel_o");
    check_read(7'h10, "dmcontrol with dmactive");
    for (int h = 0; h < `DM_NR_HARTS; h++) begin
      dmi_write(7'h10, 32'h8000_0001 | (h << 16));
      check_eq(haltreq, 1 << h, "haltreq one-hot");
      dmi_write(7'h10, 32'h0000_0001 | (h << 16));
      cra_pulses = 0;
      dmi_write(7'h10, 32'h4000_0001 | (h << 16));
      check_eq(cra_pulses, 1, "clear_resumeack pulse count");
      check_eq(resumereq, 1 << h, "resumereq one-hot");
      resumeack[h] = 1'b1;
      wait_cycles(2);
      sh_resume = 1'b0;
      check_read(7'h10, "resumereq after resumeack");
      resumeack = '0;
    end
    dmi_write(7'h10, 32'hc005_0001);
    check_eq(haltreq, '0, "haltreq for missing hart");
    check_eq(resumereq, '0, "resumereq for missing hart");
    check_eq(hartsel, 32'd5, "hartsel_o for missing hart");
    check_read(7'h11, "dmstatus nonexistent");

    // status with random hart inputs
    for (int k = 0; k < 8; k++) begin
      halted = $random(seed);
      unavail = $random(seed);
      dmi_write(7'h10, 32'h0000_0001 | ((k % `DM_NR_HARTS) << 16));
      check_read(7'h11, "dmstatus masking");
      check_read(7'h40, "haltsum0");
    end
    // hart 3 stays selected through ack and ndmreset
    dmi_write(7'h10, 32'h1003_0001);
    check_read(7'h11, "havereset after ackhavereset");
    dmi_write(7'h10, 32'h0003_0003);
    check_eq(ndmreset, 1'b1, "ndmreset_o set");
    dmi_write(7'h10, 32'h0003_0001);
    check_eq(ndmreset, 1'b0, "ndmreset_o cleared");
    check_read(7'h11, "havereset after ndmreset");
    halted = '0;
    unavail = '0;

    // ------------------------------------------------------------------
    // data, program buffer and busy handling
    // ------------------------------------------------------------------
    for (int i = 0; i < `DM_DATA_COUNT; i++) begin
      w = $random(seed);
      dmi_write(7'h04 + i, w);
      check_eq(data_out[i], w, "data_o");
      check_read(7'h04 + i, "data readback");
    end
    for (int i = 0; i < `DM_PROGBUF_SIZE; i++) begin
      w = $random(seed);
      dmi_write(7'h20 + i, w);
      check_eq(progbuf_out[i], w, "progbuf_o");
      check_read(7'h20 + i, "progbuf readback");
    end
    cmdbusy = 1'b1;
    dmi_write(7'h04, $random(seed));
    dmi_write(7'h21, $random(seed));
    check_read(7'h04, "data while busy");
    check_read(7'h21, "progbuf while busy");
    check_read(7'h16, "abstractcs busy error");
    cmdbusy = 1'b0;
    dmi_write(7'h16, 32'h0000_0700);
    check_read(7'h16, "cmderr cleared");
    dmi_write(7'h10, 32'h0000_0000);
    check_eq(dmactive, 1'b0, "dmactive_o cleared");
    wait_cycles(2);
    check_eq(data_out[0], '0, "data cleared by dmactive");
    check_eq(progbuf_out[0], '0, "progbuf cleared by dmactive");
    dmi_write(7'h10, 32'h0000_0001);
    check_read(7'h04, "data after reactivation");

    // ------------------------------------------------------------------
    // commands and autoexec
    // ------------------------------------------------------------------
    cmd_pulses = 0;
    w = $random(seed);
    dmi_write(7'h17, w);
    check_eq(cmd_pulses, 1, "command pulse count");
    check_eq(last_cmd, w, "cmd_o");
    check_read(7'h17, "command reads zero");
    dmi_write(7'h18, 32'h0008_0001);
    check_read(7'h18, "abstractauto");
    cmd_pulses = 0;
    check_read(7'h04, "autoexec data0 read");
    check_eq(cmd_pulses, 1, "autoexec on data0");
    dmi_write(7'h23, $random(seed));
    check_eq(cmd_pulses, 2, "autoexec on progbuf3");
    check_read(7'h05, "data1 read");
    dmi_write(7'h22, $random(seed));
    check_eq(cmd_pulses, 2, "no autoexec on unset bits");
    dmi_write(7'h18, 32'h0000_0000);
    cmderr_in = dm_pkg::cmderr_exception;
    cmderr_valid = 1'b1;
    @(posedge clk_i);
    #2;
    cmderr_valid = 1'b0;
    sh_cmderr = 3'd3;
    check_read(7'h16, "cmderr from hart");

    // back-pressure keeps responses in order
    resp_ready = 1'b0;
    send(dm_pkg::dtm_read, 7'h04, '0);
    send(dm_pkg::dtm_read, 7'h16, '0);
    exp0 = ref_read(7'h04);
    exp1 = ref_read(7'h16);
    check_eq(req_ready, 1'b0, "ready with full queue");
    resp_ready = 1'b1;
    get_resp(w);
    check_eq(w, exp0, "first held response");
    get_resp(w);
    check_eq(w, exp1, "second held response");

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+logic
logic/dm_pkg.sv
logic/dm_resp_fifo.sv
logic/dm_hart_ctrl.sv
logic/dm_abstract_regs.sv
logic/dm_csrs.sv
testbench/tb_dm_csrs.sv

// File: Bender.yml
package:
  name: dm_csrs

sources:
  - include_dirs:
      - logic
    files:
      - logic/dm_pkg.sv
      - logic/dm_resp_fifo.sv
      - logic/dm_hart_ctrl.sv
      - logic/dm_abstract_regs.sv
      - logic/dm_csrs.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_dm_csrs.sv
